//--- design/isa_pkg.sv
package isa_pkg;

    localparam int inst_w = 32;

    // branch type of one slot
    typedef enum logic [1:0] {
        bt_none     = 2'b00,
        bt_uncond   = 2'b01,
        bt_pcrel    = 2'b10,
        bt_indirect = 2'b11
    } btype_e;

    // ibar: top five bits plus a marker bit
    localparam logic [4:0] op_ibar_hi = 5'b00111;
    localparam int         ibar_bit   = 15;

    // csr write/exchange, only counts with rj nonzero
    localparam logic [7:0] op_csr_hi = 8'b00000100;
    localparam int         rj_lsb    = 5;
    localparam int         rj_w      = 5;

    // tlb maintenance, two full words and the invtlb prefix
    localparam logic [31:0] op_tlbsrch   = 32'b0000011_0010010000_01100_00000_00000;
    localparam logic [31:0] op_tlbrd     = 32'b0000011_0010010000_01101_00000_00000;
    localparam logic [16:0] op_invtlb_hi = 17'b0000011_0010010011;

    // unconditional b / bl
    localparam logic [5:0] op_b_hi  = 6'b010100;
    localparam logic [5:0] op_bl_hi = 6'b010101;

    // register indirect
    localparam logic [5:0] op_jirl_hi = 6'b010011;

    // pc relative conditional branches
    localparam logic [5:0] op_beqz_hi = 6'b010000;
    localparam logic [5:0] op_bnez_hi = 6'b010001;
    localparam logic [5:0] op_bcz_hi  = 6'b010010;
    localparam logic [4:0] op_bcc5_hi = 5'b01011;
    localparam logic [3:0] op_bcc4_hi = 4'b0110;

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    localparam int pc_w        = 32;
    localparam int slot_n      = 2;

    // pc bit that marks slot 0 as not a valid start
    localparam int pc_slot_bit = 2;

    localparam int queue_depth = 2;
    localparam int qptr_w      = $clog2(queue_depth);
    localparam int qcnt_w      = qptr_w + 1;

    // output side four-phase sequence
    typedef enum logic [1:0] {
        hs_idle,
        hs_req,
        hs_wait_low
    } hs_state_e;

endpackage

//--- design/fetch_pair_if.sv
`timescale 1ns/1ps

interface fetch_pair_if;
    import fetch_pkg::*;
    import isa_pkg::*;

    logic              valid;
    logic              ready;
    logic [pc_w-1:0]   pc;
    logic [inst_w-1:0] inst0;
    logic [inst_w-1:0] inst1;

    modport source (output valid, output pc, output inst0, output inst1, input ready);

    modport sink (input valid, input pc, input inst0, input inst1, output ready);

endinterface

//--- design/predecode_if.sv
`timescale 1ns/1ps

interface predecode_if;
    import fetch_pkg::*;
    import isa_pkg::*;

    logic                valid;
    logic                ready;
    logic [pc_w-1:0]     pc;
    logic [inst_w-1:0]   inst0;
    logic [inst_w-1:0]   inst1;
    logic [slot_n-1:0]   priv_flag;
    logic [slot_n-1:0]   ibar_flag;
    logic [slot_n-1:0]   csr_flag;
    logic [slot_n-1:0]   tlb_flag;
    // slot 1 in the upper half
    btype_e [slot_n-1:0] branch_flag;
    btype_e              inst_btype;

    modport source (
        output valid, output pc, output inst0, output inst1,
        output priv_flag, output ibar_flag, output csr_flag, output tlb_flag,
        output branch_flag, output inst_btype,
        input  ready
    );

    modport sink (
        input  valid, input pc, input inst0, input inst1,
        input  priv_flag, input ibar_flag, input csr_flag, input tlb_flag,
        input  branch_flag, input inst_btype,
        output ready
    );

endinterface

//--- design/fetch_capture.sv
`timescale 1ns/1ps

module fetch_capture (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_req,
    output logic                        in_ack,
    input  logic [fetch_pkg::pc_w-1:0]  in_pc,
    input  logic [isa_pkg::inst_w-1:0]  in_inst0,
    input  logic [isa_pkg::inst_w-1:0]  in_inst1,
    fetch_pair_if.source                pair
);
    import fetch_pkg::*;
    import isa_pkg::*;

    logic [pc_w-1:0]   pc_q    [queue_depth];
    logic [inst_w-1:0] inst0_q [queue_depth];
    logic [inst_w-1:0] inst1_q [queue_depth];

    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [qcnt_w-1:0] count;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    assign full  = (count == qcnt_w'(queue_depth));
    // store on req high while ack still low
    assign wr_en = in_req && !in_ack && !full;
    assign rd_en = pair.valid && pair.ready;

    // four-phase ack
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (wr_en) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_q[wr_ptr]    <= in_pc;
            inst0_q[wr_ptr] <= in_inst0;
            inst1_q[wr_ptr] <= in_inst1;
        end
    end

    // circular pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == qptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == qptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head of queue
    assign pair.valid = (count != '0);
    assign pair.pc    = pc_q[rd_ptr];
    assign pair.inst0 = inst0_q[rd_ptr];
    assign pair.inst1 = inst1_q[rd_ptr];

    // ack only answers a req seen while an entry was free
    a_ack_needs_room: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(count) < qcnt_w'(queue_depth));

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req));

endmodule

//--- design/pre_decoder.sv
`timescale 1ns/1ps

module pre_decoder (
    input  logic          clk,
    input  logic          rst,
    fetch_pair_if.sink    pair,
    predecode_if.source   dec
);
    import fetch_pkg::*;
    import isa_pkg::*;

    logic [inst_w-1:0]   inst [slot_n];
    logic [slot_n-1:0]   ibar_c;
    logic [slot_n-1:0]   csr_c;
    logic [slot_n-1:0]   tlb_c;
    btype_e [slot_n-1:0] bt_c;
    btype_e              sum_c;
    logic                take;

    // uncond wins over pcrel, pcrel over indirect
    function automatic btype_e slot_btype(input logic [inst_w-1:0] w);
        logic uncond;
        logic pcrel;
        logic indir;
        uncond = (w[inst_w-1 -: 6] == op_b_hi) || (w[inst_w-1 -: 6] == op_bl_hi);
        pcrel  = (w[inst_w-1 -: 6] == op_beqz_hi) || (w[inst_w-1 -: 6] == op_bnez_hi) ||
                 (w[inst_w-1 -: 6] == op_bcz_hi)  || (w[inst_w-1 -: 5] == op_bcc5_hi) ||
                 (w[inst_w-1 -: 4] == op_bcc4_hi);
        indir  = (w[inst_w-1 -: 6] == op_jirl_hi);
        if (uncond) begin
            return bt_uncond;
        end else if (pcrel) begin
            return bt_pcrel;
        end else if (indir) begin
            return bt_indirect;
        end
        return bt_none;
    endfunction

    assign inst[0] = pair.inst0;
    assign inst[1] = pair.inst1;

    always_comb begin
        for (int s = 0; s < slot_n; s++) begin
            ibar_c[s] = (inst[s][inst_w-1 -: 5] == op_ibar_hi) && inst[s][ibar_bit];
            csr_c[s]  = (inst[s][inst_w-1 -: 8] == op_csr_hi) && |inst[s][rj_lsb +: rj_w];
            tlb_c[s]  = (inst[s] == op_tlbsrch) || (inst[s] == op_tlbrd) ||
                        (inst[s][inst_w-1 -: 17] == op_invtlb_hi);
            bt_c[s]   = slot_btype(inst[s]);
        end
    end

    // packet summary, slot 1 first
    always_comb begin
        if (bt_c[1] != bt_none) begin
            sum_c = bt_c[1];
        end else if (pair.pc[pc_slot_bit]) begin
            // fetch started at slot 1
            sum_c = bt_none;
        end else if (bt_c[0] == bt_indirect) begin
            sum_c = bt_indirect;
        end else begin
            sum_c = bt_none;
        end
    end

    // single entry stage
    assign pair.ready = !dec.valid || dec.ready;
    assign take       = pair.valid && pair.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else if (take) begin
            dec.valid <= 1'b1;
        end else if (dec.ready) begin
            dec.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec.pc          <= pair.pc;
            dec.inst0       <= pair.inst0;
            dec.inst1       <= pair.inst1;
            dec.ibar_flag   <= ibar_c;
            dec.csr_flag    <= csr_c;
            dec.tlb_flag    <= tlb_c;
            dec.priv_flag   <= ibar_c | csr_c | tlb_c;
            dec.branch_flag <= bt_c;
            dec.inst_btype  <= sum_c;
        end
    end

    // the three privileged patterns are disjoint
    for (genvar g = 0; g < slot_n; g++) begin : g_priv_chk
        a_priv_onehot: assert property (@(posedge clk) disable iff (rst)
            dec.valid |-> $onehot0({dec.ibar_flag[g], dec.csr_flag[g], dec.tlb_flag[g]}));
    end

endmodule

//--- design/predecode_sender.sv
`timescale 1ns/1ps

module predecode_sender (
    input  logic                          clk,
    input  logic                          rst,
    predecode_if.sink                     dec,
    output logic                          out_req,
    input  logic                          out_ack,
    output logic [fetch_pkg::pc_w-1:0]    out_pc,
    output logic [isa_pkg::inst_w-1:0]    out_inst0,
    output logic [isa_pkg::inst_w-1:0]    out_inst1,
    output logic [fetch_pkg::slot_n-1:0]  out_priv_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_ibar_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_csr_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_tlb_flag,
    output logic [3:0]                    out_branch_flag,
    output isa_pkg::btype_e               out_inst_btype
);
    import fetch_pkg::*;

    hs_state_e state;

    assign dec.ready = (state == hs_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= hs_idle;
            out_req <= 1'b0;
        end else begin
            case (state)
                hs_idle: if (dec.valid) begin
                    state   <= hs_req;
                    out_req <= 1'b1;
                end
                hs_req: if (out_ack) begin
                    state   <= hs_wait_low;
                    out_req <= 1'b0;
                end
                // downstream must drop ack before the next packet
                hs_wait_low: if (!out_ack) begin
                    state <= hs_idle;
                end
                default: state <= hs_idle;
            endcase
        end
    end

    // latch packet on take
    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) begin
            out_pc          <= dec.pc;
            out_inst0       <= dec.inst0;
            out_inst1       <= dec.inst1;
            out_priv_flag   <= dec.priv_flag;
            out_ibar_flag   <= dec.ibar_flag;
            out_csr_flag    <= dec.csr_flag;
            out_tlb_flag    <= dec.tlb_flag;
            out_branch_flag <= dec.branch_flag;
            out_inst_btype  <= dec.inst_btype;
        end
    end

    a_req_holds: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req);

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        $past(out_req) && out_req |-> $stable({out_pc, out_inst0, out_inst1,
            out_priv_flag, out_ibar_flag, out_csr_flag, out_tlb_flag,
            out_branch_flag, out_inst_btype}));

endmodule

//--- design/fetch_predecode_top.sv
`timescale 1ns/1ps

module fetch_predecode_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_req,
    output logic                          in_ack,
    input  logic [fetch_pkg::pc_w-1:0]    in_pc,
    input  logic [isa_pkg::inst_w-1:0]    in_inst0,
    input  logic [isa_pkg::inst_w-1:0]    in_inst1,
    output logic                          out_req,
    input  logic                          out_ack,
    output logic [fetch_pkg::pc_w-1:0]    out_pc,
    output logic [isa_pkg::inst_w-1:0]    out_inst0,
    output logic [isa_pkg::inst_w-1:0]    out_inst1,
    output logic [fetch_pkg::slot_n-1:0]  out_priv_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_ibar_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_csr_flag,
    output logic [fetch_pkg::slot_n-1:0]  out_tlb_flag,
    output logic [3:0]                    out_branch_flag,
    output isa_pkg::btype_e               out_inst_btype
);

    fetch_pair_if pair_if ();
    predecode_if  dec_if ();

    // input handshake and queue
    fetch_capture fetch_capture_i (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_pc    (in_pc),
        .in_inst0 (in_inst0),
        .in_inst1 (in_inst1),
        .pair     (pair_if.source)
    );

    pre_decoder pre_decoder_i (
        .clk  (clk),
        .rst  (rst),
        .pair (pair_if.sink),
        .dec  (dec_if.source)
    );

    // output handshake
    predecode_sender predecode_sender_i (
        .clk             (clk),
        .rst             (rst),
        .dec             (dec_if.sink),
        .out_req         (out_req),
        .out_ack         (out_ack),
        .out_pc          (out_pc),
        .out_inst0       (out_inst0),
        .out_inst1       (out_inst1),
        .out_priv_flag   (out_priv_flag),
        .out_ibar_flag   (out_ibar_flag),
        .out_csr_flag    (out_csr_flag),
        .out_tlb_flag    (out_tlb_flag),
        .out_branch_flag (out_branch_flag),
        .out_inst_btype  (out_inst_btype)
    );

endmodule

//--- test/predecode_checker.sv
`timescale 1ns/1ps

module predecode_checker #(
    parameter int pkt_total = 400
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  logic        in_ack,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_inst0,
    input  logic [31:0] in_inst1,
    input  logic        out_req,
    input  logic        out_ack,
    input  logic [31:0] out_pc,
    input  logic [31:0] out_inst0,
    input  logic [31:0] out_inst1,
    input  logic [1:0]  out_priv_flag,
    input  logic [1:0]  out_ibar_flag,
    input  logic [1:0]  out_csr_flag,
    input  logic [1:0]  out_tlb_flag,
    input  logic [3:0]  out_branch_flag,
    input  logic [1:0]  out_inst_btype,
    input  logic        done,
    output int          value_errs,
    output int          other_errs,
    output int          out_count
);

    // tlb maintenance encodings, rj and rd zero
    localparam logic [31:0] tlbsrch_word = 32'h06483000;
    localparam logic [31:0] tlbrd_word   = 32'h06483400;
    localparam logic [16:0] invtlb_pfx   = 17'b00000110010010011;

    // {pc, inst0, inst1} in arrival order
    logic [95:0]  pending [$];
    logic [95:0]  head;
    logic [109:0] out_snap;
    logic [109:0] out_snap_d;
    logic         rst_d;
    logic         in_req_d;
    logic         in_ack_d;
    logic         out_req_d;
    logic         out_ack_d;
    logic         end_done = 1'b0;
    int           n_value  = 0;
    int           n_other  = 0;
    int           n_out    = 0;
    int           n_in     = 0;

    assign value_errs = n_value;
    assign other_errs = n_other;
    assign out_count  = n_out;
    assign out_snap   = {out_pc, out_inst0, out_inst1, out_priv_flag, out_ibar_flag,
                         out_csr_flag, out_tlb_flag, out_branch_flag, out_inst_btype};

    function automatic logic is_ibar(input logic [31:0] w);
        return (w[31:27] == 5'b00111) && w[15];
    endfunction

    function automatic logic is_csr(input logic [31:0] w);
        // rj of zero is a plain csr read
        return (w[31:24] == 8'b00000100) && (w[9:5] != 5'd0);
    endfunction

    function automatic logic is_tlb(input logic [31:0] w);
        return (w == tlbsrch_word) || (w == tlbrd_word) || (w[31:15] == invtlb_pfx);
    endfunction

    function automatic logic [1:0] branch_kind(input logic [31:0] w);
        // b and bl share the top five bits
        if (w[31:27] == 5'b01010) begin
            return 2'b01;
        end
        if ((w[31:28] == 4'b0100 && w[27:26] != 2'b11) || w[31:27] == 5'b01011 ||
            w[31:28] == 4'b0110) begin
            return 2'b10;
        end
        if (w[31:26] == 6'b010011) begin
            return 2'b11;
        end
        return 2'b00;
    endfunction

    function automatic logic [1:0] packet_kind(input logic [31:0] pc, input logic [1:0] b0,
                                               input logic [1:0] b1);
        if (b1 != 2'b00) begin
            return b1;
        end
        if (pc[2]) begin
            return 2'b00;
        end
        return (b0 == 2'b11) ? 2'b11 : 2'b00;
    endfunction

    task automatic check_field(input string name, input int idx, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s packet %0d: expected %h actual %h", name, idx, exp, act);
            n_value++;
        end
    endtask

    task automatic report_other(input string msg);
        $display("%0t: %s", $time, msg);
        n_other++;
    endtask

    task automatic compare_packet(input logic [95:0] pkt, input int idx);
        logic [31:0] pc;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [1:0]  b0;
        logic [1:0]  b1;
        logic [1:0]  e_ibar;
        logic [1:0]  e_csr;
        logic [1:0]  e_tlb;
        pc     = pkt[95:64];
        w0     = pkt[63:32];
        w1     = pkt[31:0];
        b0     = branch_kind(w0);
        b1     = branch_kind(w1);
        e_ibar = {is_ibar(w1), is_ibar(w0)};
        e_csr  = {is_csr(w1), is_csr(w0)};
        e_tlb  = {is_tlb(w1), is_tlb(w0)};
        check_field("pc", idx, pc, out_pc);
        check_field("inst0", idx, w0, out_inst0);
        check_field("inst1", idx, w1, out_inst1);
        check_field("ibar_flag", idx, 32'(e_ibar), 32'(out_ibar_flag));
        check_field("csr_flag", idx, 32'(e_csr), 32'(out_csr_flag));
        check_field("tlb_flag", idx, 32'(e_tlb), 32'(out_tlb_flag));
        check_field("priv_flag", idx, 32'(e_ibar | e_csr | e_tlb), 32'(out_priv_flag));
        check_field("branch_flag", idx, 32'({b1, b0}), 32'(out_branch_flag));
        check_field("inst_btype", idx, 32'(packet_kind(pc, b0, b1)), 32'(out_inst_btype));
    endtask

    always @(posedge clk) begin
        if (rst_d === 1'b1 && (in_ack !== 1'b0 || out_req !== 1'b0)) begin
            report_other("in_ack or out_req not low during or right after reset");
        end
        if (!rst && !rst_d) begin
            if (in_ack && !in_ack_d) begin
                if (!in_req_d) begin
                    report_other("in_ack rose while in_req was low");
                end
                pending.push_back({in_pc, in_inst0, in_inst1});
                n_in++;
            end
            if (out_req && !out_req_d) begin
                if (pending.size() == 0) begin
                    report_other("out_req rose with no input packet pending");
                end else begin
                    head = pending.pop_front();
                    compare_packet(head, n_out);
                end
                n_out++;
            end
            if (!out_req && out_req_d && !out_ack_d) begin
                report_other("out_req dropped before out_ack was seen");
            end
            if (out_req && out_req_d && out_snap !== out_snap_d) begin
                report_other("output data changed while out_req was high");
            end
        end
        // completeness, once at the end of the run
        if (done && !end_done) begin
            end_done = 1'b1;
            if (n_in != pkt_total) begin
                report_other($sformatf("%0d packets accepted, expected %0d", n_in, pkt_total));
            end
            if (n_out != pkt_total) begin
                report_other($sformatf("%0d packets sent out, expected %0d", n_out, pkt_total));
            end
            if (pending.size() != 0) begin
                report_other($sformatf("%0d packets never left the DUT", pending.size()));
            end
        end
        rst_d      <= rst;
        in_req_d   <= in_req;
        in_ack_d   <= in_ack;
        out_req_d  <= out_req;
        out_ack_d  <= out_ack;
        out_snap_d <= out_snap;
    end

endmodule

//--- test/tb_fetch_predecode.sv
`timescale 1ns/1ps

module tb_fetch_predecode;

    localparam int          n_packets     = 400;
    localparam int          reset_cycles  = 16;
    localparam int          timeout_limit = n_packets * 20 + reset_cycles;
    localparam logic [31:0] seed          = 32'hcfcf5158;

    logic            clk;
    logic            rst;
    logic            in_req;
    logic            in_ack;
    logic [31:0]     in_pc;
    logic [31:0]     in_inst0;
    logic [31:0]     in_inst1;
    logic            out_req;
    logic            out_ack;
    logic [31:0]     out_pc;
    logic [31:0]     out_inst0;
    logic [31:0]     out_inst1;
    logic [1:0]      out_priv_flag;
    logic [1:0]      out_ibar_flag;
    logic [1:0]      out_csr_flag;
    logic [1:0]      out_tlb_flag;
    logic [3:0]      out_branch_flag;
    isa_pkg::btype_e out_inst_btype;
    logic            done;
    int              value_errs;
    int              other_errs;
    int              out_count;
    int              cycles = 0;

    // stimulus for both sides drawn up front
    logic [31:0] pc_a    [n_packets];
    logic [31:0] inst0_a [n_packets];
    logic [31:0] inst1_a [n_packets];
    int          gap_a   [n_packets];
    int          rise_a  [n_packets];
    int          fall_a  [n_packets];

    fetch_predecode_top fetch_predecode_top_i (.*);

    predecode_checker #(.pkt_total(n_packets)) predecode_checker_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pattern class from the top bits of ra
    function automatic logic [31:0] make_inst(input logic [31:0] ra, input logic [31:0] rb);
        logic [31:0] w;
        w = {rb[31:16], ra[27:12]};
        case (ra[31:28])
            4'd0: begin
                w[31:27] = 5'b00111;
                w[15]    = 1'b1;
            end
            // ibar prefix without the marker bit
            4'd1: begin
                w[31:27] = 5'b00111;
                w[15]    = 1'b0;
            end
            4'd2: w[31:24] = 8'b00000100;
            4'd3: begin
                w[31:24] = 8'b00000100;
                w[9:5]   = 5'd0;
            end
            4'd4: w = 32'h06483000;
            4'd5: w = 32'h06483400;
            4'd6: w[31:15] = 17'b00000110010010011;
            4'd7: w[31:27] = 5'b01010;
            4'd8: w[31:26] = 6'b010011;
            4'd9: begin
                w[31:28] = 4'b0100;
                w[27:26] = (w[27:26] == 2'b11) ? 2'b00 : w[27:26];
            end
            4'd10: w[31:27] = 5'b01011;
            4'd11: w[31:28] = 4'b0110;
            default: ;
        endcase
        return w;
    endfunction

    task automatic build_stimulus();
        logic [31:0] rnd;
        logic [31:0] r [5];
        rnd = seed;
        for (int i = 0; i < n_packets; i++) begin
            for (int j = 0; j < 5; j++) begin
                rnd  = lcg_next(rnd);
                r[j] = rnd;
            end
            inst0_a[i] = make_inst(r[0], r[1]);
            inst1_a[i] = make_inst(r[2], r[3]);
            pc_a[i]    = {r[4][31:12], r[1][15:7], r[4][22], 2'b00};
            gap_a[i]   = int'(r[3][15:14]);
            // now and then a long wait before out_ack
            rise_a[i]  = (r[3][13:11] == 3'd0) ? 12 + int'(r[4][21:18]) : int'(r[4][17:15]);
            fall_a[i]  = int'(r[3][10:9]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // four-phase upstream side
    task automatic send_packet(input logic [31:0] pc, input logic [31:0] i0,
                               input logic [31:0] i1);
        in_pc    = pc;
        in_inst0 = i0;
        in_inst1 = i1;
        in_req   = 1'b1;
        next_cycle();
        while (in_ack !== 1'b1) next_cycle();
        in_req = 1'b0;
        next_cycle();
        while (in_ack !== 1'b0) next_cycle();
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol or completeness; packets out %0d of %0d",
                 value_errs, other_errs, out_count, n_packets);
    endtask

    initial begin
        rst      = 1'b1;
        in_req   = 1'b0;
        in_pc    = '0;
        in_inst0 = '0;
        in_inst1 = '0;
        out_ack  = 1'b0;
        done     = 1'b0;
        build_stimulus();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < n_packets; i++) begin
            repeat (gap_a[i]) next_cycle();
            send_packet(pc_a[i], inst0_a[i], inst1_a[i]);
        end
        while (out_count < n_packets) next_cycle();
        // let the last output handshake finish
        while (out_req !== 1'b0 || out_ack !== 1'b0) next_cycle();
        // room for a stray extra packet to show up
        repeat (8) next_cycle();
        done = 1'b1;
        repeat (2) next_cycle();
        print_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // downstream ack with random delays
    initial begin : ack_responder
        int k;
        k = 0;
        forever begin
            while (out_req !== 1'b1) next_cycle();
            repeat (rise_a[k % n_packets]) next_cycle();
            out_ack = 1'b1;
            while (out_req !== 1'b0) next_cycle();
            repeat (fall_a[k % n_packets]) next_cycle();
            out_ack = 1'b0;
            k++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d of %0d packets out",
                     cycles, out_count, n_packets);
            print_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

//--- fetch_predecode_top.f
design/isa_pkg.sv
design/fetch_pkg.sv
design/fetch_pair_if.sv
design/predecode_if.sv
design/fetch_capture.sv
design/pre_decoder.sv
design/predecode_sender.sv
design/fetch_predecode_top.sv
test/predecode_checker.sv
test/tb_fetch_predecode.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_predecode \
    -f fetch_predecode_top.f

sim_out=$(./obj_dir/Vtb_fetch_predecode)
echo "$sim_out"

if grep -qx '>>> PASS' <<< "$sim_out"; then
    exit 0
fi
exit 1
